/* Makefile */
# Verilator flow for the RDMX shim testbench

VERILATOR ?= verilator
TOP       ?= tb_rdmx_shim
DUT       ?= rdmx_shim
FILELIST  ?= rdmx_shim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/frame_sequencer.sv */
/* Frame sequencer
   Counts packets and half frames, steps through data, metadata and counter */
`timescale 1ns/1ps

module frame_sequencer import rdmx_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic [15:0]     packet_size,
    input  logic [31:0]     frame_size,
    shim_ctrl_if.seq        ctrl,
    input  logic            md_full,
    output logic            md_beat_sel,
    output logic            md_release,
    output count_t          frame_count,
    output logic            eof
);

`include "rdmx_settings.svh"

    seq_state_t state;
    count_t     packet_count;
    count_t     pkt_per_half;

    // ------------------------------------------------------------
    // Packets per half frame
    // ------------------------------------------------------------
    // Each shift also covers the halving
    // The other half of the frame goes to a second shim
    always_comb begin
        case (packet_size)
            16'd8:    pkt_per_half = frame_size >> 4;
            16'd16:   pkt_per_half = frame_size >> 5;
            16'd32:   pkt_per_half = frame_size >> 6;
            16'd64:   pkt_per_half = frame_size >> 7;
            16'd128:  pkt_per_half = frame_size >> 8;
            16'd256:  pkt_per_half = frame_size >> 9;
            16'd512:  pkt_per_half = frame_size >> 10;
            16'd1024: pkt_per_half = frame_size >> 11;
            16'd2048: pkt_per_half = frame_size >> 12;
            default:  pkt_per_half = count_t'(1);
        endcase
    end

    // ------------------------------------------------------------
    // Mode and strobes
    // ------------------------------------------------------------
    always_comb begin
        case (state)
            ST_XFER: ctrl.mode = OM_FD;
            // Hold metadata back until the whole block is in
            ST_MD:   ctrl.mode = md_full ? OM_MD : OM_IDLE;
            ST_FC:   ctrl.mode = OM_FC;
            default: ctrl.mode = OM_IDLE;
        endcase
    end

    assign ctrl.restart = (state == ST_START);
    assign md_release   = (state == ST_MD) && ctrl.burst_end;
    // End of half frame, the counter beat went out
    assign eof          = (state == ST_FC) && ctrl.beat_done;

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= ST_RESET;
            packet_count <= '0;
            frame_count  <= '0;
            md_beat_sel  <= 1'b0;
        end else begin
            case (state)
                ST_RESET: state <= ST_START;

                ST_START: begin
                    packet_count <= count_t'(1);
                    frame_count  <= count_t'(1);
                    md_beat_sel  <= 1'b0;
                    state        <= ST_XFER;
                end

                // One packet per burst
                ST_XFER: if (ctrl.burst_end) begin
                    if (packet_count >= pkt_per_half) begin
                        state <= ST_MD;
                    end else begin
                        packet_count <= packet_count + 1'b1;
                    end
                end

                ST_MD: if (ctrl.beat_done) begin
                    if (ctrl.burst_end) begin
                        md_beat_sel <= 1'b0;
                        state       <= ST_FC;
                    end else begin
                        md_beat_sel <= md_beat_sel + 1'b1;
                    end
                end

                ST_FC: if (ctrl.beat_done) begin
                    frame_count  <= frame_count + 1'b1;
                    packet_count <= count_t'(1);
                    state        <= ST_XFER;
                end

                default: state <= ST_RESET;
            endcase
        end
    end

endmodule

/* design/md_capture.sv */
/* Metadata capture
   Collects one metadata block from its stream and holds it until released */
`timescale 1ns/1ps

module md_capture import rdmx_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  data_t tdata,
    input  logic  tvalid,
    output logic  tready,
    input  logic  md_release,
    output data_t md_beats [`MD_BEATS],
    output logic  md_full
);

`include "rdmx_settings.svh"

    localparam int IDX_BITS = $clog2(`MD_BEATS);

    // Slot that the next incoming beat goes to
    logic [IDX_BITS-1:0] wr_idx;

    // tready is a register so it stays low through reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_idx  <= '0;
            md_full <= 1'b0;
            tready  <= 1'b0;
        end else if (md_full) begin
            // Block is held until the sequencer has written it out
            if (md_release) begin
                md_full <= 1'b0;
                tready  <= 1'b1;
            end
        end else if (tvalid && tready) begin
            if (wr_idx == IDX_BITS'(`MD_BEATS - 1)) begin
                wr_idx  <= '0;
                md_full <= 1'b1;
                tready  <= 1'b0;
            end else begin
                wr_idx <= wr_idx + 1'b1;
            end
        end else begin
            // First cycle out of reset, open the stream
            tready <= 1'b1;
        end
    end

    // Beat storage
    always_ff @(posedge clk) begin
        if (tvalid && tready) begin
            md_beats[wr_idx] <= tdata;
        end
    end

endmodule

/* design/rdmx_pkg.sv */
/* RDMX shim types
   Vector types for the data path and the enums of the control FSM */
package rdmx_pkg;

`include "rdmx_settings.svh"

    // One beat of stream or W data
    typedef logic [`DATA_BITS-1:0]  data_t;
    typedef logic [`DATA_BYTES-1:0] strb_t;

    // Byte address or offset into a ring
    typedef logic [`ADDR_BITS-1:0]  addr_t;

    // Frame and packet counters
    typedef logic [`FC_BITS-1:0]    count_t;

    // AXI burst length, beats minus one
    typedef logic [7:0]             len_t;

    // What the W channel is carrying right now
    typedef enum logic [1:0] {
        OM_IDLE,
        OM_FD,
        OM_MD,
        OM_FC
    } out_mode_t;

    // Sequencer states
    typedef enum logic [2:0] {
        ST_RESET,
        ST_START,
        ST_XFER,
        ST_MD,
        ST_FC
    } seq_state_t;

endpackage

/* design/rdmx_settings.svh */
/* RDMX shim settings
   Widths of the data path, the AXI address and the metadata block */
`ifndef RDMX_SETTINGS_SVH
`define RDMX_SETTINGS_SVH

// Stream and AXI data beat
`define DATA_BITS  64
`define DATA_BYTES (`DATA_BITS / 8)

// AXI byte address
`define ADDR_BITS  64

// One metadata block, in beats and in bytes
`define MD_BEATS   2
`define MD_BYTES   (`MD_BEATS * `DATA_BYTES)

// Frame counter written after every half frame
`define FC_BITS    32

`endif

/* design/rdmx_shim.sv */
/* RDMX shim top level
   Writes frame-data packets, metadata and a frame counter as AXI4 bursts */
`timescale 1ns/1ps

module rdmx_shim import rdmx_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // Geometry
    input  logic [15:0] packet_size,
    input  logic [31:0] frame_size,
    input  addr_t       fd_ring_addr,
    input  addr_t       fd_ring_size,
    input  addr_t       md_ring_addr,
    input  addr_t       md_ring_size,
    input  addr_t       fc_addr,
    // Frame-data stream
    input  data_t       axis_fd_tdata,
    input  logic        axis_fd_tvalid,
    input  logic        axis_fd_tlast,
    output logic        axis_fd_tready,
    // Metadata stream
    input  data_t       axis_md_tdata,
    input  logic        axis_md_tvalid,
    output logic        axis_md_tready,
    // AXI4 write address
    output addr_t       m_axi_awaddr,
    output len_t        m_axi_awlen,
    output logic [2:0]  m_axi_awsize,
    output logic [1:0]  m_axi_awburst,
    output logic [2:0]  m_axi_awprot,
    output logic        m_axi_awvalid,
    // AXI4 write data
    output data_t       m_axi_wdata,
    output strb_t       m_axi_wstrb,
    output logic        m_axi_wlast,
    output logic        m_axi_wvalid,
    input  logic        m_axi_wready,
    output logic        m_axi_bready,
    // Debug
    output count_t      frame_count,
    output logic        eof
);

`include "rdmx_settings.svh"

    shim_ctrl_if ctrl ();

    data_t md_beats [`MD_BEATS];
    logic  md_full;
    logic  md_release;
    logic  md_beat_sel;

    // ------------------------------------------------------------
    // Constant AXI attributes
    // ------------------------------------------------------------
    // INCR bursts, privileged, full-width beats
    assign m_axi_awsize  = 3'($clog2(`DATA_BYTES));
    assign m_axi_awburst = 2'b01;
    assign m_axi_awprot  = 3'b001;
    // Write responses are always taken
    assign m_axi_bready  = 1'b1;

    md_capture u_md_capture (
        .clk        (clk),
        .resetn     (resetn),
        .tdata      (axis_md_tdata),
        .tvalid     (axis_md_tvalid),
        .tready     (axis_md_tready),
        .md_release (md_release),
        .md_beats   (md_beats),
        .md_full    (md_full)
    );

    frame_sequencer u_frame_sequencer (
        .clk         (clk),
        .resetn      (resetn),
        .packet_size (packet_size),
        .frame_size  (frame_size),
        .ctrl        (ctrl.seq),
        .md_full     (md_full),
        .md_beat_sel (md_beat_sel),
        .md_release  (md_release),
        .frame_count (frame_count),
        .eof         (eof)
    );

    ring_addr_gen u_ring_addr_gen (
        .clk          (clk),
        .ctrl         (ctrl.addr),
        .packet_size  (packet_size),
        .fd_ring_addr (fd_ring_addr),
        .fd_ring_size (fd_ring_size),
        .md_ring_addr (md_ring_addr),
        .md_ring_size (md_ring_size),
        .fc_addr      (fc_addr),
        .awaddr       (m_axi_awaddr),
        .awlen        (m_axi_awlen),
        .awvalid      (m_axi_awvalid)
    );

    write_mux u_write_mux (
        .ctrl        (ctrl.wr),
        .fd_tdata    (axis_fd_tdata),
        .fd_tvalid   (axis_fd_tvalid),
        .fd_tlast    (axis_fd_tlast),
        .fd_tready   (axis_fd_tready),
        .md_beats    (md_beats),
        .md_beat_sel (md_beat_sel),
        .frame_count (frame_count),
        .wready      (m_axi_wready),
        .wdata       (m_axi_wdata),
        .wstrb       (m_axi_wstrb),
        .wlast       (m_axi_wlast),
        .wvalid      (m_axi_wvalid)
    );

endmodule

/* design/ring_addr_gen.sv */
/* Ring address generator
   Frame-data and metadata ring offsets and the AW channel */
`timescale 1ns/1ps

module ring_addr_gen import rdmx_pkg::*; (
    input  logic         clk,
    shim_ctrl_if.addr    ctrl,
    input  logic [15:0]  packet_size,
    input  addr_t        fd_ring_addr,
    input  addr_t        fd_ring_size,
    input  addr_t        md_ring_addr,
    input  addr_t        md_ring_size,
    input  addr_t        fc_addr,
    output addr_t        awaddr,
    output len_t         awlen,
    output logic         awvalid
);

`include "rdmx_settings.svh"

    localparam int BEAT_SHIFT = $clog2(`DATA_BYTES);

    addr_t fd_off;
    addr_t md_off;
    logic  first_beat;

    addr_t next_fd_off;
    addr_t next_md_off;
    assign next_fd_off = fd_off + addr_t'(packet_size);
    assign next_md_off = md_off + addr_t'(`MD_BYTES);

    // ------------------------------------------------------------
    // Ring offsets, cleared by restart
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctrl.restart) begin
            fd_off <= '0;
            md_off <= '0;
        end else if (ctrl.burst_end) begin
            // Wrap when the next slot would run past the ring
            if (ctrl.mode == OM_FD) begin
                fd_off <= (next_fd_off >= fd_ring_size) ? '0 : next_fd_off;
            end else if (ctrl.mode == OM_MD) begin
                md_off <= (next_md_off >= md_ring_size) ? '0 : next_md_off;
            end
        end
    end

    // Set between bursts, cleared once a burst has started
    always_ff @(posedge clk) begin
        if (ctrl.restart || ctrl.burst_end) begin
            first_beat <= 1'b1;
        end else if (ctrl.beat_done) begin
            first_beat <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // AW channel
    // ------------------------------------------------------------
    always_comb begin
        case (ctrl.mode)
            OM_FD: begin
                awaddr = fd_ring_addr + fd_off;
                awlen  = len_t'((packet_size >> BEAT_SHIFT) - 16'd1);
            end
            OM_MD: begin
                awaddr = md_ring_addr + md_off;
                awlen  = len_t'(`MD_BEATS - 1);
            end
            OM_FC: begin
                awaddr = fc_addr;
                awlen  = '0;
            end
            default: begin
                awaddr = '0;
                awlen  = '0;
            end
        endcase
    end

    // Address goes out with the first accepted beat
    assign awvalid = ctrl.beat_done && first_beat;

endmodule

/* design/shim_ctrl_if.sv */
/* Shim control bundle
   Output mode from the sequencer and W beat events from the write mux */
`timescale 1ns/1ps

interface shim_ctrl_if import rdmx_pkg::*; ();

    out_mode_t mode;
    // One-cycle pulse in ST_START
    logic      restart;
    // W beat accepted
    logic      beat_done;
    // Accepted beat carried WLAST
    logic      burst_end;

    modport seq  (output mode, restart, input beat_done, burst_end);
    modport addr (input mode, restart, beat_done, burst_end);
    modport wr   (input mode, output beat_done, burst_end);

endinterface

/* design/write_mux.sv */
/* Write data mux
   W channel selection by mode and back-pressure to the frame-data stream */
`timescale 1ns/1ps

module write_mux import rdmx_pkg::*; (
    shim_ctrl_if.wr ctrl,
    input  data_t   fd_tdata,
    input  logic    fd_tvalid,
    input  logic    fd_tlast,
    output logic    fd_tready,
    input  data_t   md_beats [`MD_BEATS],
    input  logic    md_beat_sel,
    input  count_t  frame_count,
    input  logic    wready,
    output data_t   wdata,
    output strb_t   wstrb,
    output logic    wlast,
    output logic    wvalid
);

`include "rdmx_settings.svh"

    // Counter beat only touches its own bytes
    localparam strb_t FC_STRB = strb_t'((1 << (`FC_BITS / 8)) - 1);

    always_comb begin
        wdata  = '0;
        wstrb  = '1;
        wlast  = 1'b0;
        wvalid = 1'b0;
        case (ctrl.mode)
            // Straight through from the stream
            OM_FD: begin
                wdata  = fd_tdata;
                wlast  = fd_tlast;
                wvalid = fd_tvalid;
            end
            OM_MD: begin
                wdata  = md_beats[md_beat_sel];
                wlast  = (md_beat_sel == 1'(`MD_BEATS - 1));
                wvalid = 1'b1;
            end
            OM_FC: begin
                wdata  = data_t'(frame_count);
                wstrb  = FC_STRB;
                wlast  = 1'b1;
                wvalid = 1'b1;
            end
            default: ;
        endcase
    end

    // Stream only moves when the W side takes the beat
    assign fd_tready      = (ctrl.mode == OM_FD) && wready;

    assign ctrl.beat_done = wvalid && wready;
    assign ctrl.burst_end = wvalid && wready && wlast;

endmodule

/* rdmx_shim.f */
+incdir+design
design/rdmx_pkg.sv
design/shim_ctrl_if.sv
design/md_capture.sv
design/frame_sequencer.sv
design/ring_addr_gen.sv
design/write_mux.sv
design/rdmx_shim.sv
sim/rdmx_shim_assert.sv
sim/tb_rdmx_shim.sv

/* sim/rdmx_shim_assert.sv */
/* RDMX shim AXI checks
   Concurrent assertions on the W and AW outputs and the frame-data stream */
`timescale 1ns/1ps

module rdmx_shim_assert import rdmx_pkg::*; (
    input logic  clk,
    input logic  resetn,
    input logic  m_axi_awvalid,
    input data_t m_axi_wdata,
    input logic  m_axi_wlast,
    input logic  m_axi_wvalid,
    input logic  m_axi_wready,
    input data_t axis_fd_tdata,
    input logic  axis_fd_tvalid,
    input logic  axis_fd_tlast,
    input logic  axis_fd_tready
);

    // Failed checks, read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    // One AW pulse per burst, gone by the second beat
    aw_single_pulse: assert property (@(posedge clk) disable iff (!resetn)
        m_axi_awvalid && !m_axi_wlast |=> !m_axi_awvalid)
        else begin
            fail_count++;
            $error("AWVALID held into the second beat of a burst");
        end

    // A stalled W beat keeps its valid, data and last
    w_hold: assert property (@(posedge clk) disable iff (!resetn)
        m_axi_wvalid && !m_axi_wready |=>
            m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wlast))
        else begin
            fail_count++;
            $error("W beat changed while WREADY was low");
        end

    // Stream ready only while stream beats pass straight to W
    fd_ready_in_xfer: assert property (@(posedge clk) disable iff (!resetn)
        axis_fd_tready |-> m_axi_wready && m_axi_wvalid == axis_fd_tvalid &&
            m_axi_wlast == axis_fd_tlast && m_axi_wdata == axis_fd_tdata)
        else begin
            fail_count++;
            $error("Frame-data TREADY high outside a frame-data beat");
        end

endmodule

/* sim/tb_rdmx_shim.sv */
/* RDMX shim testbench
   Random streams and WREADY stalls, every write checked against a model queue */
`timescale 1ns/1ps

module tb_rdmx_shim import rdmx_pkg::*; ();

`include "rdmx_settings.svh"

    // 4-beat packets, 3 packets per half frame
    localparam int    PACKET_BYTES   = 32;
    localparam int    FRAME_BYTES    = 192;
    localparam int    BEATS          = PACKET_BYTES / `DATA_BYTES;
    localparam int    PKTS           = 3;
    localparam int    N_HALF         = 6;
    localparam int    FD_BEATS       = N_HALF * PKTS * BEATS;
    localparam int    MD_TOTAL       = N_HALF * `MD_BEATS;
    localparam int    TOTAL_BEATS    = FD_BEATS + MD_TOTAL + N_HALF;
    localparam int    TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 200;
    // Small rings, both wrap several times over the run
    localparam addr_t FD_RING        = 64'h0000_0040_0000_0000;
    localparam addr_t FD_SIZE        = 64'd160;
    localparam addr_t MD_RING        = 64'h0000_0040_0001_0000;
    localparam addr_t MD_SIZE        = 64'd48;
    localparam addr_t FC_ADDR        = 64'h0000_0040_0002_0000;
    // Fixed AXI attributes of every burst
    // 8-byte beats, INCR bursts, privileged data access
    localparam logic [2:0] AW_SIZE   = 3'd3;
    localparam logic [1:0] AW_INCR   = 2'b01;
    localparam logic [2:0] AW_PRIV   = 3'b001;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
        logic  first;
        logic  fc;
    } w_beat_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } aw_req_t;

    logic        clk;
    logic        resetn;
    logic [15:0] packet_size;
    logic [31:0] frame_size;
    addr_t       fd_ring_addr;
    addr_t       fd_ring_size;
    addr_t       md_ring_addr;
    addr_t       md_ring_size;
    addr_t       fc_addr;
    data_t       axis_fd_tdata;
    logic        axis_fd_tvalid;
    logic        axis_fd_tlast;
    logic        axis_fd_tready;
    data_t       axis_md_tdata;
    logic        axis_md_tvalid;
    logic        axis_md_tready;
    addr_t       m_axi_awaddr;
    len_t        m_axi_awlen;
    logic [2:0]  m_axi_awsize;
    logic [1:0]  m_axi_awburst;
    logic [2:0]  m_axi_awprot;
    logic        m_axi_awvalid;
    data_t       m_axi_wdata;
    strb_t       m_axi_wstrb;
    logic        m_axi_wlast;
    logic        m_axi_wvalid;
    logic        m_axi_wready;
    logic        m_axi_bready;
    count_t      frame_count;
    logic        eof;

    // Stimulus and model state
    data_t   fd_data [FD_BEATS];
    data_t   md_data [MD_TOTAL];
    w_beat_t w_q [$];
    aw_req_t aw_q [$];
    int      fd_idx;
    int      md_idx;
    logic    fd_hs;
    logic    md_hs;
    int      errors;
    int      err_mark;
    int      tests_run;
    int      tests_failed;
    int      eof_count;
    int      half_reported;
    int      cycle_count;

    rdmx_shim uut (.*);

    bind rdmx_shim rdmx_shim_assert u_assert (
        .clk            (clk),
        .resetn         (resetn),
        .m_axi_awvalid  (m_axi_awvalid),
        .m_axi_wdata    (m_axi_wdata),
        .m_axi_wlast    (m_axi_wlast),
        .m_axi_wvalid   (m_axi_wvalid),
        .m_axi_wready   (m_axi_wready),
        .axis_fd_tdata  (axis_fd_tdata),
        .axis_fd_tvalid (axis_fd_tvalid),
        .axis_fd_tlast  (axis_fd_tlast),
        .axis_fd_tready (axis_fd_tready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit from the number of expected beats
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d W beats never arrived", cycle_count, w_q.size());
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------
    // Model of the expected writes
    // ------------------------------------------------------------
    function automatic void expect_burst(addr_t addr, len_t len);
        aw_req_t req;
        req.addr = addr;
        req.len  = len;
        aw_q.push_back(req);
    endfunction

    function automatic void expect_beat(data_t d, strb_t s, logic last, logic first, logic fc);
        w_beat_t beat;
        beat.data  = d;
        beat.strb  = s;
        beat.last  = last;
        beat.first = first;
        beat.fc    = fc;
        w_q.push_back(beat);
    endfunction

    function automatic void fill_stimulus();
        foreach (fd_data[i]) begin
            fd_data[i] = {$urandom, $urandom};
        end
        foreach (md_data[i]) begin
            md_data[i] = {$urandom, $urandom};
        end
    endfunction

    // Per half frame: packets, then the metadata block, then the counter word
    function automatic void build_expected();
        addr_t fd_off;
        addr_t md_off;
        addr_t nxt;
        int    k;
        fd_off = '0;
        md_off = '0;
        k      = 0;
        for (int h = 0; h < N_HALF; h++) begin
            for (int p = 0; p < PKTS; p++) begin
                expect_burst(FD_RING + fd_off, len_t'(BEATS - 1));
                for (int b = 0; b < BEATS; b++) begin
                    expect_beat(fd_data[k], '1, b == BEATS - 1, b == 0, 1'b0);
                    k++;
                end
                // Offset wraps once the next slot would reach the ring size
                nxt    = fd_off + addr_t'(PACKET_BYTES);
                fd_off = (nxt >= FD_SIZE) ? '0 : nxt;
            end
            expect_burst(MD_RING + md_off, len_t'(`MD_BEATS - 1));
            for (int b = 0; b < `MD_BEATS; b++) begin
                expect_beat(md_data[h * `MD_BEATS + b], '1, b == `MD_BEATS - 1, b == 0, 1'b0);
            end
            nxt    = md_off + addr_t'(`MD_BYTES);
            md_off = (nxt >= MD_SIZE) ? '0 : nxt;
            // Counter starts at 1, low 4 bytes only
            expect_burst(FC_ADDR, len_t'(0));
            expect_beat(data_t'(h + 1), strb_t'(8'h0F), 1'b1, 1'b1, 1'b1);
        end
    endfunction

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    function automatic void drive_streams();
        if (fd_hs) begin
            fd_idx++;
        end
        // A beat on offer stays until it is taken
        if (!axis_fd_tvalid || fd_hs) begin
            if (fd_idx < FD_BEATS) begin
                axis_fd_tvalid = ($urandom % 4) != 0;
                axis_fd_tdata  = fd_data[fd_idx];
                axis_fd_tlast  = (fd_idx % BEATS) == BEATS - 1;
            end else begin
                axis_fd_tvalid = 1'b0;
            end
        end
        if (md_hs) begin
            md_idx++;
        end
        if (!axis_md_tvalid || md_hs) begin
            if (md_idx < MD_TOTAL) begin
                axis_md_tvalid = ($urandom % 4) != 0;
                axis_md_tdata  = md_data[md_idx];
            end else begin
                axis_md_tvalid = 1'b0;
            end
        end
        m_axi_wready = ($urandom % 4) != 0;
    endfunction

    // Drive on the falling edge, note stream handshakes on the rising edge
    task automatic step_cycle();
        drive_streams();
        @(posedge clk);
        fd_hs = axis_fd_tvalid && axis_fd_tready;
        md_hs = axis_md_tvalid && axis_md_tready;
        @(negedge clk);
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic check_quiet();
        if (m_axi_wvalid !== 1'b0 || m_axi_awvalid !== 1'b0 || eof !== 1'b0 ||
            axis_fd_tready !== 1'b0) begin
            $display("Error at %0t: outputs active around reset, %s %b %b %b %b",
                     $time, "wvalid awvalid eof tready", m_axi_wvalid, m_axi_awvalid,
                     eof, axis_fd_tready);
            errors++;
        end
    endtask

    task automatic check_beat();
        w_beat_t want;
        aw_req_t req;
        if (w_q.size() == 0) begin
            $display("W beat accepted at %0t after the last expected write", $time);
            errors++;
        end else begin
            want = w_q.pop_front();
            if (m_axi_wdata !== want.data) begin
                $display("Error at %0t: WDATA %h, expected %h", $time, m_axi_wdata, want.data);
                errors++;
            end
            if (m_axi_wstrb !== want.strb || m_axi_wlast !== want.last) begin
                $display("Error at %0t: WSTRB %h WLAST %b, expected %h %b",
                         $time, m_axi_wstrb, m_axi_wlast, want.strb, want.last);
                errors++;
            end
            if (eof !== want.fc) begin
                $display("Error at %0t: eof %b, expected %b", $time, eof, want.fc);
                errors++;
            end
            // Debug counter matches the counter word being written
            if (want.fc && frame_count !== count_t'(want.data)) begin
                $display("Error at %0t: frame_count %0d, expected %0d",
                         $time, frame_count, count_t'(want.data));
                errors++;
            end
            if (want.first) begin
                req = aw_q.pop_front();
                if (m_axi_awvalid !== 1'b1) begin
                    $display("No AWVALID on the first beat of a burst at %0t", $time);
                    errors++;
                end else begin
                    if (m_axi_awaddr !== req.addr || m_axi_awlen !== req.len) begin
                        $display("Error at %0t: AW %h len %0d, expected %h len %0d",
                                 $time, m_axi_awaddr, m_axi_awlen, req.addr, req.len);
                        errors++;
                    end
                    if (m_axi_awsize !== AW_SIZE || m_axi_awburst !== AW_INCR ||
                        m_axi_awprot !== AW_PRIV) begin
                        $display("Error at %0t: AW size %0d burst %b prot %b, expected %0d %b %b",
                                 $time, m_axi_awsize, m_axi_awburst, m_axi_awprot,
                                 AW_SIZE, AW_INCR, AW_PRIV);
                        errors++;
                    end
                end
            end else if (m_axi_awvalid !== 1'b0) begin
                $display("AWVALID raised inside a burst at %0t", $time);
                errors++;
            end
        end
        if (eof === 1'b1) begin
            eof_count++;
        end
    endtask

    // Memory-side monitor
    always @(posedge clk) begin
        if (resetn) begin
            if (m_axi_bready !== 1'b1) begin
                $display("Error at %0t: BREADY %b, expected 1", $time, m_axi_bready);
                errors++;
            end
            if (m_axi_wvalid && m_axi_wready) begin
                check_beat();
            end else if (m_axi_awvalid || eof) begin
                $display("AWVALID or eof raised at %0t without an accepted W beat", $time);
                errors++;
            end
        end
    end

    function automatic void report_test(string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endfunction

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(30));
        errors         = 0;
        err_mark       = 0;
        tests_run      = 0;
        tests_failed   = 0;
        eof_count      = 0;
        half_reported  = 0;
        fd_idx         = 0;
        md_idx         = 0;
        fd_hs          = 1'b0;
        md_hs          = 1'b0;
        resetn         = 1'b0;
        packet_size    = 16'(PACKET_BYTES);
        frame_size     = 32'(FRAME_BYTES);
        fd_ring_addr   = FD_RING;
        fd_ring_size   = FD_SIZE;
        md_ring_addr   = MD_RING;
        md_ring_size   = MD_SIZE;
        fc_addr        = FC_ADDR;
        axis_fd_tdata  = '0;
        axis_fd_tvalid = 1'b0;
        axis_fd_tlast  = 1'b0;
        axis_md_tdata  = '0;
        axis_md_tvalid = 1'b0;
        // WREADY high so a stray stream TREADY would show
        m_axi_wready   = 1'b1;
        fill_stimulus();
        build_expected();

        // Outputs looked at mid-cycle, after each reset edge
        repeat (4) begin
            @(negedge clk);
            check_quiet();
            if (axis_md_tready !== 1'b0) begin
                $display("Error at %0t: metadata TREADY %b during reset", $time, axis_md_tready);
                errors++;
            end
        end
        resetn = 1'b1;
        // ST_RESET and ST_START
        repeat (2) begin
            check_quiet();
            @(negedge clk);
        end
        report_test("reset quiet");

        while (half_reported < N_HALF) begin
            step_cycle();
            while (half_reported < eof_count) begin
                half_reported++;
                report_test($sformatf("half frame %0d", half_reported));
            end
        end
        // Idle stretch to catch any extra write
        repeat (20) begin
            step_cycle();
        end
        if (w_q.size() != 0) begin
            $display("Run ended with %0d expected W beats never written", w_q.size());
            errors++;
        end
        errors += int'(uut.u_assert.fail_count);
        report_test("drain and assertions");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
